// File: bench/mem_model.sv
`timescale 1ns/1ps
`include "l1_cache_settings.svh"

module mem_model (
    input  logic                          clk,
    input  logic                          proc_reset,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic [`L1_MEM_ADDR_WIDTH-1:0] mem_addr,
    input  cache_pkg::block_t             mem_wdata,
    output cache_pkg::block_t             mem_rdata,
    output logic                          mem_ready,
    output int                            rd_count,
    output int                            wr_count,
    output logic [`L1_MEM_ADDR_WIDTH-1:0] last_wr_addr,
    output cache_pkg::block_t             last_wr_data
);

    // only written blocks are stored, the rest follow the fill pattern
    cache_pkg::block_t blocks [logic [`L1_MEM_ADDR_WIDTH-1:0]];

    int left;

    function automatic cache_pkg::block_t block_at(input logic [`L1_MEM_ADDR_WIDTH-1:0] addr);
        cache_pkg::block_t b;
        if (blocks.exists(addr)) begin
            b = blocks[addr];
        end else begin
            for (int w = 0; w < `L1_WORD_NUM; w++) begin
                // word address xor C0DE in the upper half-word
                b[w] = {2'b00, addr, w[1:0]} ^ 32'hC0DE_0000;
            end
        end
        return b;
    endfunction

    initial begin
        mem_ready    = 1'b0;
        mem_rdata    = '0;
        rd_count     = 0;
        wr_count     = 0;
        last_wr_addr = '0;
        last_wr_data = '0;
        left         = 0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_ready) begin
                mem_ready = 1'b0;
            end else if (!proc_reset && (mem_read || mem_write)) begin
                // new request, pick its latency
                if (left == 0) begin
                    left = 1 + int'($urandom % 4);
                end
                left--;
                if (left == 0) begin
                    mem_ready = 1'b1;
                    if (mem_write) begin
                        blocks[mem_addr] = mem_wdata;
                        last_wr_addr     = mem_addr;
                        last_wr_data     = mem_wdata;
                        wr_count++;
                    end else begin
                        mem_rdata = block_at(mem_addr);
                        rd_count++;
                    end
                end
            end
        end
    end

endmodule

// File: bench/tb_cache.sv
`timescale 1ns/1ps
`include "l1_cache_settings.svh"

module tb_cache;

    localparam int WAIT_LIMIT = 200;
    localparam int RANDOM_OPS = 300;

    logic                          clk;
    logic                          proc_reset;
    logic                          proc_read;
    logic                          proc_write;
    logic [`L1_ADDR_WIDTH-1:0]     proc_addr;
    cache_pkg::word_t              proc_wdata;
    logic                          proc_stall;
    cache_pkg::word_t              proc_rdata;
    logic                          mem_read;
    logic                          mem_write;
    logic [`L1_MEM_ADDR_WIDTH-1:0] mem_addr;
    cache_pkg::block_t             mem_rdata;
    cache_pkg::block_t             mem_wdata;
    logic                          mem_ready;
    int                            rd_count;
    int                            wr_count;
    logic [`L1_MEM_ADDR_WIDTH-1:0] last_wr_addr;
    cache_pkg::block_t             last_wr_data;

    // words as the processor last wrote them
    cache_pkg::word_t golden [logic [`L1_ADDR_WIDTH-1:0]];

    int errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;

    cache_top DUT (.*);

    mem_model u_mem (.*);

    always #2 clk = ~clk;

    // idle cache with no request
    assert property (@(posedge clk) disable iff (proc_reset)
        !(proc_read || proc_write) |-> !proc_stall && !mem_read && !mem_write)
        else begin
            errors++;
            $display("stall or memory request raised while the processor was idle");
        end

    // a fill fetches the block that missed
    assert property (@(posedge clk) disable iff (proc_reset)
        mem_read |-> mem_addr == proc_addr[29:2])
        else begin
            errors++;
            $display("Fail fill_address: expected %h, actual %h", proc_addr[29:2], mem_addr);
        end

    // the victim is never the requested block
    assert property (@(posedge clk) disable iff (proc_reset)
        mem_write |-> mem_addr != proc_addr[29:2])
        else begin
            errors++;
            $display("write-back addressed the block that was requested");
        end

    function automatic cache_pkg::word_t golden_word(input logic [`L1_ADDR_WIDTH-1:0] addr);
        if (golden.exists(addr)) begin
            return golden[addr];
        end else begin
            return {2'b00, addr} ^ 32'hC0DE_0000;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_at_start);
        end else begin
            $display("%s: passed", name);
        end
        errors_at_start = errors;
    endtask

    // one processor access, returns once proc_stall is low
    task automatic access(input logic write, input logic [`L1_ADDR_WIDTH-1:0] addr,
                          input cache_pkg::word_t wdata, output cache_pkg::word_t rdata,
                          output int stall_cycles);
        @(posedge clk);
        #1;
        proc_read    = !write;
        proc_write   = write;
        proc_addr    = addr;
        proc_wdata   = wdata;
        stall_cycles = 0;
        #1;
        while (proc_stall && stall_cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            stall_cycles++;
        end
        if (proc_stall) begin
            $display("proc_stall stayed high for %0d cycles at address %h", WAIT_LIMIT, addr);
            $display("TEST FAILED");
            $finish;
        end else begin
            rdata = proc_rdata;
            if (write) begin
                golden[addr] = wdata;
            end
        end
    endtask

    task automatic drop_request();
        @(posedge clk);
        #1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
    endtask

    initial begin
        cache_pkg::word_t          rdata;
        cache_pkg::word_t          wdata;
        cache_pkg::word_t          expected;
        int                        stalls;
        int                        rd_before;
        int                        wr_before;
        logic                      write;
        logic [`L1_ADDR_WIDTH-1:0] rand_addr;
        logic [`L1_ADDR_WIDTH-1:0] first_addr;
        logic [`L1_ADDR_WIDTH-1:0] dirty_addr;
        logic [`L1_ADDR_WIDTH-1:0] second_addr;
        logic [`L1_ADDR_WIDTH-1:0] third_addr;

        void'($urandom(32'h3599));
        clk             = 1'b0;
        proc_reset      = 1'b1;
        proc_read       = 1'b0;
        proc_write      = 1'b0;
        proc_addr       = '0;
        proc_wdata      = '0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        // three tags in set 1
        first_addr  = {26'h123, 2'd1, 2'd2};
        dirty_addr  = {26'h123, 2'd1, 2'd3};
        second_addr = {26'h456, 2'd1, 2'd0};
        third_addr  = {26'h789, 2'd1, 2'd1};

        repeat (3) @(posedge clk);
        #1;
        proc_reset = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        check_value("reset", 32'd0, 32'({proc_stall, mem_read, mem_write}));
        report_test("reset");

        rd_before = rd_count;
        access(1'b0, first_addr, '0, rdata, stalls);
        check_value("read_miss", 32'(rd_before + 1), 32'(rd_count));
        check_value("read_miss", golden_word(first_addr), rdata);
        report_test("read_miss");

        rd_before = rd_count;
        wr_before = wr_count;
        access(1'b1, dirty_addr, 32'hDEAD_BEEF, rdata, stalls);
        check_value("write_hit", 32'd0, 32'(stalls));
        check_value("write_hit", 32'(rd_before + wr_before), 32'(rd_count + wr_count));
        access(1'b0, dirty_addr, '0, rdata, stalls);
        check_value("write_hit", 32'hDEAD_BEEF, rdata);
        report_test("write_hit");

        access(1'b0, second_addr, '0, rdata, stalls);
        check_value("two_ways", golden_word(second_addr), rdata);
        // touch order leaves the dirty block as LRU
        rd_before = rd_count;
        wr_before = wr_count;
        access(1'b0, first_addr, '0, rdata, stalls);
        check_value("two_ways", golden_word(first_addr), rdata);
        access(1'b0, second_addr, '0, rdata, stalls);
        check_value("two_ways", golden_word(second_addr), rdata);
        check_value("two_ways", 32'(rd_before + wr_before), 32'(rd_count + wr_count));
        report_test("two_ways");

        wr_before = wr_count;
        access(1'b0, third_addr, '0, rdata, stalls);
        check_value("dirty_evict", 32'(wr_before + 1), 32'(wr_count));
        check_value("dirty_evict", 32'(first_addr[29:2]), 32'(last_wr_addr));
        for (int w = 0; w < `L1_WORD_NUM; w++) begin
            check_value("dirty_evict", golden_word({first_addr[29:2], w[1:0]}), last_wr_data[w]);
        end
        check_value("dirty_evict", golden_word(third_addr), rdata);
        // evicted word comes back from memory
        rd_before = rd_count;
        access(1'b0, dirty_addr, '0, rdata, stalls);
        check_value("dirty_evict", 32'(rd_before + 1), 32'(rd_count));
        check_value("dirty_evict", 32'hDEAD_BEEF, rdata);
        report_test("dirty_evict");

        // 16 blocks over 4 sets, so evictions are frequent
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rand_addr = 30'h200 + 30'($urandom % 64);
            write     = ($urandom % 5) < 2;
            wdata     = $urandom;
            expected  = golden_word(rand_addr);
            access(write, rand_addr, wdata, rdata, stalls);
            if (!write) begin
                check_value("random_mix", expected, rdata);
            end
        end
        drop_request();
        report_test("random_mix");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps
`include "l1_cache_settings.svh"

module cache_ctrl (
    input  logic                          clk,
    input  logic                          proc_reset,
    input  logic                          proc_read,
    input  logic                          proc_write,
    input  cache_pkg::addr_fields_t       fields,
    input  cache_pkg::lookup_t            lookup,
    input  logic                          mem_ready,
    output logic                          proc_stall,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic [`L1_MEM_ADDR_WIDTH-1:0] mem_addr,
    output cache_pkg::store_cmd_t         cmd
);

    cache_pkg::ctrl_state_e state;
    cache_pkg::ctrl_state_e state_next;

    logic request;
    logic hit;

    assign request = proc_read || proc_write;

    // a lookup only counts once the miss sequence is over
    assign hit = (state == cache_pkg::st_compare) && lookup.any_hit;

    assign proc_stall = request && !hit;

    // memory requests follow the state directly
    assign mem_write = (state == cache_pkg::st_write_back);
    assign mem_read  = (state == cache_pkg::st_allocate);

    // victim block on write-back, requested block otherwise
    assign mem_addr = mem_write ? {lookup.victim_tag, fields.index}
                                : {fields.tag, fields.index};

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            state <= cache_pkg::st_compare;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        cmd.op     = cache_pkg::op_none;
        cmd.way    = lookup.hit_way;
        cmd.tag    = fields.tag;
        case (state)
            cache_pkg::st_compare: begin
                if (request && lookup.any_hit) begin
                    cmd.op = proc_write ? cache_pkg::op_word_write : cache_pkg::op_touch;
                end else if (request) begin
                    // dirty victim must reach memory before the fill
                    if (lookup.victim_needs_wb) begin
                        state_next = cache_pkg::st_write_back;
                    end else begin
                        state_next = cache_pkg::st_allocate;
                    end
                end
            end
            cache_pkg::st_write_back: begin
                cmd.way = lookup.victim_way;
                if (mem_ready) begin
                    cmd.op     = cache_pkg::op_clean;
                    state_next = cache_pkg::st_allocate;
                end
            end
            cache_pkg::st_allocate: begin
                cmd.way = lookup.victim_way;
                if (mem_ready) begin
                    // LRU is left alone here, the replayed hit touches it
                    cmd.op     = cache_pkg::op_fill;
                    state_next = cache_pkg::st_compare;
                end
            end
            default: begin
                state_next = cache_pkg::st_compare;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (proc_reset) !(mem_read && mem_write))
        else $error("cache_ctrl: mem_read and mem_write both high");

    assert property (@(posedge clk) disable iff (proc_reset) !(proc_read && proc_write))
        else $error("cache_ctrl: proc_read and proc_write both high");

    // relies on the processor holding its request through the stall
    assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready |=> $stable(mem_addr))
        else $error("cache_ctrl: mem_addr changed before mem_ready");

endmodule

// File: hw/cache_pkg.sv
`include "l1_cache_settings.svh"

package cache_pkg;

    typedef logic [`L1_WORD_WIDTH-1:0] word_t;

    // word 0 sits in the low bits of the block
    typedef word_t [`L1_WORD_NUM-1:0] block_t;

    typedef logic [`L1_TAG_WIDTH-1:0]    tag_t;
    typedef logic [`L1_INDEX_WIDTH-1:0]  index_t;
    typedef logic [`L1_OFFSET_WIDTH-1:0] offset_t;
    typedef logic [$clog2(`L1_WAY_NUM)-1:0] way_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_fields_t;

    typedef struct packed {
        logic [`L1_WAY_NUM-1:0] hit;
        logic                   any_hit;
        way_t                   hit_way;
        // the LRU way of the addressed set
        way_t                   victim_way;
        logic                   victim_needs_wb;
        tag_t                   victim_tag;
    } lookup_t;

    typedef enum logic [2:0] {
        op_none,
        op_touch,
        op_word_write,
        op_fill,
        op_clean
    } store_op_e;

    // set index comes from addr_fields_t in both stores
    typedef struct packed {
        store_op_e op;
        way_t      way;
        tag_t      tag;
    } store_cmd_t;

    typedef enum logic [1:0] {
        st_compare,
        st_write_back,
        st_allocate
    } ctrl_state_e;

endpackage

// File: hw/cache_top.sv
`timescale 1ns/1ps
`include "l1_cache_settings.svh"

module cache_top (
    input  logic                          clk,
    input  logic                          proc_reset,
    input  logic                          proc_read,
    input  logic                          proc_write,
    input  logic [`L1_ADDR_WIDTH-1:0]     proc_addr,
    input  cache_pkg::word_t              proc_wdata,
    output logic                          proc_stall,
    output cache_pkg::word_t              proc_rdata,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic [`L1_MEM_ADDR_WIDTH-1:0] mem_addr,
    input  cache_pkg::block_t             mem_rdata,
    input  logic                          mem_ready,
    output cache_pkg::block_t             mem_wdata
);

    cache_pkg::addr_fields_t fields;
    cache_pkg::lookup_t      lookup;
    cache_pkg::store_cmd_t   cmd;

    // word offset low, set index next, tag on top
    assign fields.offset = proc_addr[`L1_OFFSET_WIDTH-1:0];
    assign fields.index  = proc_addr[`L1_OFFSET_WIDTH +: `L1_INDEX_WIDTH];
    assign fields.tag    = proc_addr[`L1_ADDR_WIDTH-1 -: `L1_TAG_WIDTH];

    cache_ctrl u_ctrl (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .fields     (fields),
        .lookup     (lookup),
        .mem_ready  (mem_ready),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .cmd        (cmd)
    );

    tag_store u_tags (
        .clk        (clk),
        .proc_reset (proc_reset),
        .fields     (fields),
        .cmd        (cmd),
        .lookup     (lookup)
    );

    // victim block goes straight out as write-back data
    data_store u_data (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .fields      (fields),
        .lookup      (lookup),
        .cmd         (cmd),
        .wdata       (proc_wdata),
        .fill_data   (mem_rdata),
        .rdata       (proc_rdata),
        .victim_data (mem_wdata)
    );

endmodule

// File: hw/data_store.sv
`timescale 1ns/1ps
`include "l1_cache_settings.svh"

module data_store (
    input  logic                    clk,
    input  logic                    proc_reset,
    input  cache_pkg::addr_fields_t fields,
    input  cache_pkg::lookup_t      lookup,
    input  cache_pkg::store_cmd_t   cmd,
    input  cache_pkg::word_t        wdata,
    input  cache_pkg::block_t       fill_data,
    output cache_pkg::word_t        rdata,
    output cache_pkg::block_t       victim_data
);

    cache_pkg::block_t blocks [`L1_SET_NUM][`L1_WAY_NUM];

    cache_pkg::block_t hit_block;
    cache_pkg::block_t set_victim;

    // hit way of the addressed set
    assign hit_block = blocks[fields.index][lookup.hit_way];

    // word select by offset, only meaningful on a hit
    assign rdata = hit_block[fields.offset];

    // LRU block, held while a write-back waits on memory
    assign set_victim  = blocks[fields.index][lookup.victim_way];
    assign victim_data = set_victim;

    always_ff @(posedge clk) begin
        if (!proc_reset) begin
            case (cmd.op)
                cache_pkg::op_word_write: begin
                    blocks[fields.index][cmd.way][fields.offset] <= wdata;
                end
                // whole block from memory
                cache_pkg::op_fill: begin
                    blocks[fields.index][cmd.way] <= fill_data;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: hw/tag_store.sv
`timescale 1ns/1ps
`include "l1_cache_settings.svh"

module tag_store (
    input  logic                    clk,
    input  logic                    proc_reset,
    input  cache_pkg::addr_fields_t fields,
    input  cache_pkg::store_cmd_t   cmd,
    output cache_pkg::lookup_t      lookup
);

    logic [`L1_WAY_NUM-1:0] valid [`L1_SET_NUM];
    logic [`L1_WAY_NUM-1:0] dirty [`L1_SET_NUM];
    // names the way to evict next
    cache_pkg::way_t        lru   [`L1_SET_NUM];
    cache_pkg::tag_t        tags  [`L1_SET_NUM][`L1_WAY_NUM];

    logic [`L1_WAY_NUM-1:0] set_valid;
    logic [`L1_WAY_NUM-1:0] set_dirty;
    cache_pkg::way_t        victim;

    assign set_valid = valid[fields.index];
    assign set_dirty = dirty[fields.index];
    assign victim    = lru[fields.index];

    always_comb begin
        lookup = '0;
        for (int w = 0; w < `L1_WAY_NUM; w++) begin
            lookup.hit[w] = set_valid[w] && (tags[fields.index][w] == fields.tag);
        end
        lookup.any_hit = |lookup.hit;
        // scan downwards so the lower way wins
        for (int w = `L1_WAY_NUM - 1; w >= 0; w--) begin
            if (lookup.hit[w]) begin
                lookup.hit_way = cache_pkg::way_t'(w);
            end
        end
        lookup.victim_way      = victim;
        lookup.victim_needs_wb = set_valid[victim] && set_dirty[victim];
        lookup.victim_tag      = tags[fields.index][victim];
    end

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            for (int s = 0; s < `L1_SET_NUM; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                lru[s]   <= '0;
            end
        end else begin
            case (cmd.op)
                cache_pkg::op_touch: begin
                    lru[fields.index] <= ~cmd.way;
                end
                cache_pkg::op_word_write: begin
                    lru[fields.index]            <= ~cmd.way;
                    dirty[fields.index][cmd.way] <= 1'b1;
                end
                cache_pkg::op_fill: begin
                    valid[fields.index][cmd.way] <= 1'b1;
                    dirty[fields.index][cmd.way] <= 1'b0;
                end
                cache_pkg::op_clean: begin
                    dirty[fields.index][cmd.way] <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // tag array, written only by a fill
    always_ff @(posedge clk) begin
        if (!proc_reset && cmd.op == cache_pkg::op_fill) begin
            tags[fields.index][cmd.way] <= cmd.tag;
        end
    end

    // fills only follow a miss, so a tag lives in one way of its set
    assert property (@(posedge clk) disable iff (proc_reset) $onehot0(lookup.hit))
        else $error("tag_store: several ways hit in set %0d", fields.index);

endmodule

// File: include/l1_cache_settings.svh
`ifndef L1_CACHE_SETTINGS_SVH
`define L1_CACHE_SETTINGS_SVH

// data word and block geometry
`define L1_WORD_WIDTH 32
`define L1_WORD_NUM 4

// 2 ways x 4 sets, 8 blocks in all
`define L1_WAY_NUM 2
`define L1_SET_NUM 4

// word address from the processor, block address to memory
`define L1_ADDR_WIDTH 30
`define L1_MEM_ADDR_WIDTH 28

// processor address fields, offset in the low bits
`define L1_OFFSET_WIDTH 2
`define L1_INDEX_WIDTH 2
`define L1_TAG_WIDTH 26

`endif

// File: l1_cache.f
+incdir+include
hw/cache_pkg.sv
hw/tag_store.sv
hw/data_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
bench/mem_model.sv
bench/tb_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --assert --top-module tb_cache -f l1_cache.f \
        -o tb_cache_sim 2>&1 \
    && ./obj_dir/tb_cache_sim 2>&1)

echo "$out"

grep -qx "TEST OK" <<< "$out" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
